/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

  typedef logic [31:0] word_t;    // Data, address and register value
  typedef logic [3:0]  regIdx_t;  // Low nibble of a register field

  localparam int      NumRegs        = 16;
  localparam regIdx_t SpReg          = 4'd0;   // Stack pointer
  localparam regIdx_t FlagReg        = 4'd1;   // Compare flags
  localparam word_t   InstrBytes     = 32'd4;
  localparam word_t   LongInstrBytes = 32'd8;  // Opcode word plus constant word
  localparam word_t   StackStep      = 32'd4;

  // Bit positions in the flag register
  localparam int FlagEq = 0;
  localparam int FlagLt = 1;
  localparam int FlagGt = 2;

  // Opcode in bits 7:0 of the instruction word
  typedef enum logic [7:0] {
    Stall     = 8'h00,  // All-zero word parks the core
    MovRC     = 8'h01,
    MovRR     = 8'h02,
    PackRRR   = 8'h03,
    AddRRC    = 8'h10,
    AddRRR    = 8'h11,
    SubRRC    = 8'h12,
    SubRRR    = 8'h13,
    IncR      = 8'h14,
    DecR      = 8'h15,
    ShlRRR    = 8'h16,
    ShrRRR    = 8'h17,
    NegRR     = 8'h18,
    MulAddRRC = 8'h19,
    CmpRR     = 8'h20,  // Flag compares
    CmpRC     = 8'h21,
    CmpERRR   = 8'h22,  // Compares into a register
    CmpLtRRR  = 8'h23,
    CmpGtRRR  = 8'h24,
    MovRdC    = 8'h30,  // Loads
    MovRdRo   = 8'h31,
    MovRdRoR  = 8'h32,
    MovdCR    = 8'h33,  // Stores
    MovdRoR   = 8'h34,
    MovdRoRR  = 8'h35,
    PushR     = 8'h40,
    PopR      = 8'h41,
    CallR     = 8'h42,
    Ret       = 8'h43,
    JmpC      = 8'h50,
    JeC       = 8'h51,
    JneC      = 8'h52,
    JzRC      = 8'h53,
    DoutR     = 8'h60
  } opcode_t;

  typedef enum logic [3:0] {
    Fetch,
    FetchWait,
    Decode,
    RegRead,
    WordWait,
    WordComplete,
    MemRequest,
    MemWait,
    MemComplete,
    Execute
  } seqState_t;

  // Constant word follows at pc+4
  function automatic logic isLong(input opcode_t op);
    case (op)
      MovRC, AddRRC, SubRRC, MulAddRRC, CmpRC,
      MovRdC, MovRdRo, MovRdRoR, MovdCR, MovdRoR, MovdRoRR,
      JmpC, JeC, JneC, JzRC: isLong = 1'b1;
      default:               isLong = 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* cpuSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuSequencer
  import cpuPkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire word_t ramIn,
  input  wire        memRead,      // Data phase wanted, from memAddrGen
  input  wire        memWrite,
  input  wire word_t memAddress,
  input  wire word_t memData,
  input  wire word_t nextPc,       // From execUnit, loaded in Execute
  output word_t      ramAddress,
  output word_t      ramOut,
  output logic       readReq,
  output logic       writeReq,
  output opcode_t    opcode,
  output regIdx_t    dstIdx,
  output regIdx_t    srcAIdx,
  output regIdx_t    srcBIdx,
  output word_t      dataWord,     // Constant word of long opcodes
  output word_t      loadValue,    // Data read in the memory phase
  output word_t      pc,
  output logic       captureOperands,
  output logic       executeStrobe
);

  seqState_t state;
  logic      longOp;   // Constant word still to fetch
  logic      memOp;

  assign longOp = isLong(opcode);
  assign memOp  = memRead | memWrite;

  // Requests are one-cycle pulses raised on entry to the requesting state
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= Fetch;
      pc       <= '0;
      opcode   <= Stall;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      case (state)
        Fetch: begin
          if (readReq) begin
            readReq <= 1'b0;
            state   <= FetchWait;
          end else begin
            readReq <= 1'b1;   // Only right after reset
          end
        end
        FetchWait: begin
          state <= Decode;   // Memory drives ramIn
        end
        Decode: begin
          // Two edges after the fetch request
          opcode  <= opcode_t'(ramIn[7:0]);
          readReq <= isLong(opcode_t'(ramIn[7:0]));  // Constant word request during RegRead
          state   <= RegRead;
        end
        RegRead: begin
          readReq <= 1'b0;
          if (longOp) begin
            state <= WordWait;
          end else if (memOp) begin
            readReq  <= memRead;
            writeReq <= memWrite;
            state    <= MemRequest;
          end else begin
            state <= Execute;
          end
        end
        WordWait: begin
          state <= WordComplete;
        end
        WordComplete: begin
          if (memOp) begin
            readReq  <= memRead;
            writeReq <= memWrite;
            state    <= MemRequest;
          end else begin
            state <= Execute;
          end
        end
        MemRequest: begin
          readReq  <= 1'b0;
          writeReq <= 1'b0;
          state    <= MemWait;
        end
        MemWait: begin
          state <= MemComplete;
        end
        MemComplete: begin
          state <= Execute;
        end
        Execute: begin
          pc      <= nextPc;
          readReq <= 1'b1;   // Next fetch, address follows pc
          state   <= Fetch;
        end
        default: begin
          state <= Fetch;
        end
      endcase
    end
  end

  // Instruction fields and fetched words
  always_ff @(posedge clk) begin
    if (state == Decode) begin
      dstIdx  <= ramIn[11:8];
      srcAIdx <= ramIn[19:16];
      srcBIdx <= ramIn[27:24];
    end
    if (state == WordComplete) begin
      dataWord <= ramIn;
    end
    if (state == MemComplete) begin
      loadValue <= ramIn;   // Unused after stores
    end
  end

  // Address held steady through each phase
  always_comb begin
    case (state)
      RegRead, WordWait, WordComplete:  ramAddress = pc + InstrBytes;
      MemRequest, MemWait, MemComplete: ramAddress = memAddress;
      default:                          ramAddress = pc;
    endcase
  end

  assign ramOut          = memData;
  assign captureOperands = (state == RegRead);
  assign executeStrobe   = (state == Execute);

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
  import cpuPkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire regIdx_t srcDIdx,
  input  wire regIdx_t srcAIdx,
  input  wire regIdx_t srcBIdx,
  input  wire          captureOperands,
  input  wire          regWrite,      // General port
  input  wire regIdx_t writeIdx,
  input  wire word_t   writeData,
  input  wire          spWrite,       // Stack pointer port
  input  wire word_t   spNext,
  output word_t        opD,
  output word_t        opA,
  output word_t        opB,
  output word_t        sp,
  output word_t        flags
);

  word_t regs [NumRegs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (spWrite) begin
        regs[SpReg] <= spNext;
      end
      // Assigned last so it wins a clash on r0
      if (regWrite) begin
        regs[writeIdx] <= writeData;
      end
    end
  end

  // Operands held for the rest of the instruction
  always_ff @(posedge clk) begin
    if (captureOperands) begin
      opD <= regs[srcDIdx];
      opA <= regs[srcAIdx];
      opB <= regs[srcBIdx];
    end
  end

  assign sp    = regs[SpReg];
  assign flags = regs[FlagReg];

endmodule

`default_nettype wire

/* memAddrGen.sv */
`timescale 1ns/1ps
`default_nettype none

module memAddrGen
  import cpuPkg::*;
(
  input  wire opcode_t opcode,
  input  wire word_t   opD,
  input  wire word_t   opA,
  input  wire word_t   opB,
  input  wire word_t   dataWord,
  input  wire word_t   sp,
  input  wire word_t   pc,
  output logic         memRead,
  output logic         memWrite,
  output word_t        memAddress,
  output word_t        memData
);

  always_comb begin
    memRead    = 1'b0;
    memWrite   = 1'b0;
    memAddress = dataWord;   // Absolute address
    memData    = opA;
    case (opcode)
      MovRdC: begin
        memRead = 1'b1;
      end
      MovRdRo: begin
        memRead    = 1'b1;
        memAddress = opA + dataWord;   // Base plus offset
      end
      MovRdRoR: begin
        memRead    = 1'b1;
        memAddress = opA + dataWord * opB;   // Base plus size times index
      end
      MovdCR: begin
        memWrite = 1'b1;
      end
      MovdRoR: begin
        memWrite   = 1'b1;
        memAddress = opD + dataWord;
      end
      MovdRoRR: begin
        memWrite   = 1'b1;
        memAddress = opD + dataWord * opA;
        memData    = opB;
      end
      PushR: begin
        memWrite   = 1'b1;
        memAddress = sp;   // Stack grows upward
        memData    = opD;
      end
      CallR: begin
        memWrite   = 1'b1;
        memAddress = sp;
        memData    = pc;   // Own address, Ret adds 4
      end
      PopR, Ret: begin
        memRead    = 1'b1;
        memAddress = sp - StackStep;   // Top entry
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit
  import cpuPkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire          executeStrobe,
  input  wire opcode_t opcode,
  input  wire regIdx_t dstIdx,
  input  wire word_t   opD,
  input  wire word_t   opA,
  input  wire word_t   opB,
  input  wire word_t   dataWord,
  input  wire word_t   loadValue,
  input  wire word_t   pc,
  input  wire word_t   sp,
  input  wire word_t   flags,
  output logic         regWrite,
  output regIdx_t      writeIdx,
  output word_t        writeData,
  output logic         spWrite,
  output word_t        spNext,
  output word_t        nextPc,
  output word_t        debugOut,
  output logic         debugValid
);

  logic  writesReg;
  logic  stepsSp;
  word_t cmpRhs;       // Second compare operand
  word_t fallThrough;

  assign cmpRhs      = (opcode == CmpRC) ? dataWord : opA;
  assign fallThrough = pc + (isLong(opcode) ? LongInstrBytes : InstrBytes);

  always_comb begin
    writesReg = 1'b1;
    stepsSp   = 1'b0;
    writeIdx  = dstIdx;
    writeData = opA;
    spNext    = sp;
    case (opcode)
      MovRC:     writeData = dataWord;
      MovRR:     writeData = opA;
      AddRRC:    writeData = opA + dataWord;
      AddRRR:    writeData = opA + opB;
      SubRRC:    writeData = opA - dataWord;
      SubRRR:    writeData = opA - opB;
      IncR:      writeData = opD + 32'd1;
      DecR:      writeData = opD - 32'd1;
      ShlRRR:    writeData = opA << opB;
      ShrRRR:    writeData = opA >> opB;
      NegRR:     writeData = -opA;
      MulAddRRC: writeData = opD + opA * dataWord;
      PackRRR: begin
        writeData                    = opD;
        writeData[opB[1:0] * 8 +: 8] = opA[7:0];  // Byte lane from opB
      end
      CmpRR, CmpRC: begin
        writeIdx          = FlagReg;
        writeData         = flags;   // Upper bits untouched
        writeData[FlagEq] = (opD == cmpRhs);
        writeData[FlagLt] = (opD < cmpRhs);
        writeData[FlagGt] = (opD > cmpRhs);
      end
      CmpERRR:   writeData = word_t'(opA == opB);
      CmpLtRRR:  writeData = word_t'(opA < opB);
      CmpGtRRR:  writeData = word_t'(opA > opB);
      MovRdC, MovRdRo, MovRdRoR: writeData = loadValue;
      PopR: begin
        writeData = loadValue;
        stepsSp   = 1'b1;
        spNext    = sp - StackStep;
      end
      PushR, CallR: begin
        writesReg = 1'b0;
        stepsSp   = 1'b1;
        spNext    = sp + StackStep;
      end
      Ret: begin
        writesReg = 1'b0;
        stepsSp   = 1'b1;
        spNext    = sp - StackStep;
      end
      default: writesReg = 1'b0;   // Stores, jumps, debug, stall
    endcase
  end

  assign regWrite = executeStrobe & writesReg;
  assign spWrite  = executeStrobe & stepsSp;

  // Branch decision
  always_comb begin
    case (opcode)
      JmpC:    nextPc = dataWord;
      JeC:     nextPc = flags[FlagEq] ? dataWord : fallThrough;
      JneC:    nextPc = flags[FlagEq] ? fallThrough : dataWord;
      JzRC:    nextPc = (opB == '0) ? dataWord : fallThrough;
      CallR:   nextPc = opD;
      Ret:     nextPc = loadValue + InstrBytes;   // Past the call
      Stall:   nextPc = pc;
      default: nextPc = fallThrough;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      debugValid <= 1'b0;
    end else begin
      debugValid <= executeStrobe && (opcode == DoutR);
    end
  end

  always_ff @(posedge clk) begin
    if (executeStrobe && (opcode == DoutR)) begin
      debugOut <= opD;
    end
  end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop
  import cpuPkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire word_t ramIn,       // Read data, valid from the request edge
  output wire word_t ramAddress,
  output wire word_t ramOut,
  output wire        readReq,
  output wire        writeReq,
  output wire word_t debugOut,
  output wire        debugValid,
  output wire word_t pc
);

  // Decoded instruction
  wire opcode_t opcode;
  wire regIdx_t dstIdx;
  wire regIdx_t srcAIdx;
  wire regIdx_t srcBIdx;
  wire word_t   dataWord;
  wire word_t   loadValue;

  // Operands and architectural taps
  wire word_t   opD;
  wire word_t   opA;
  wire word_t   opB;
  wire word_t   sp;
  wire word_t   flags;

  // Memory intent
  wire          memRead;
  wire          memWrite;
  wire word_t   memAddress;
  wire word_t   memData;

  // Write-back
  wire          captureOperands;
  wire          executeStrobe;
  wire          regWrite;
  wire regIdx_t writeIdx;
  wire word_t   writeData;
  wire          spWrite;
  wire word_t   spNext;
  wire word_t   nextPc;

  cpuSequencer i_sequencer (
    .clk             (clk),
    .reset           (reset),
    .ramIn           (ramIn),
    .memRead         (memRead),
    .memWrite        (memWrite),
    .memAddress      (memAddress),
    .memData         (memData),
    .nextPc          (nextPc),
    .ramAddress      (ramAddress),
    .ramOut          (ramOut),
    .readReq         (readReq),
    .writeReq        (writeReq),
    .opcode          (opcode),
    .dstIdx          (dstIdx),
    .srcAIdx         (srcAIdx),
    .srcBIdx         (srcBIdx),
    .dataWord        (dataWord),
    .loadValue       (loadValue),
    .pc              (pc),
    .captureOperands (captureOperands),
    .executeStrobe   (executeStrobe)
  );

  regFile i_regFile (
    .clk             (clk),
    .reset           (reset),
    .srcDIdx         (dstIdx),    // Destination field doubles as first operand
    .srcAIdx         (srcAIdx),
    .srcBIdx         (srcBIdx),
    .captureOperands (captureOperands),
    .regWrite        (regWrite),
    .writeIdx        (writeIdx),
    .writeData       (writeData),
    .spWrite         (spWrite),
    .spNext          (spNext),
    .opD             (opD),
    .opA             (opA),
    .opB             (opB),
    .sp              (sp),
    .flags           (flags)
  );

  memAddrGen i_addrGen (
    .opcode     (opcode),
    .opD        (opD),
    .opA        (opA),
    .opB        (opB),
    .dataWord   (dataWord),
    .sp         (sp),
    .pc         (pc),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .memAddress (memAddress),
    .memData    (memData)
  );

  execUnit i_exec (
    .clk           (clk),
    .reset         (reset),
    .executeStrobe (executeStrobe),
    .opcode        (opcode),
    .dstIdx        (dstIdx),
    .opD           (opD),
    .opA           (opA),
    .opB           (opB),
    .dataWord      (dataWord),
    .loadValue     (loadValue),
    .pc            (pc),
    .sp            (sp),
    .flags         (flags),
    .regWrite      (regWrite),
    .writeIdx      (writeIdx),
    .writeData     (writeData),
    .spWrite       (spWrite),
    .spNext        (spNext),
    .nextPc        (nextPc),
    .debugOut      (debugOut),
    .debugValid    (debugValid)
  );

endmodule

`default_nettype wire

/* cpu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuChk
  import cpuPkg::*;
(
  input wire          clk,
  input wire          reset,
  input wire          readReq,
  input wire          writeReq,
  input wire          debugValid,
  input wire          executeStrobe,
  input wire word_t   ramAddress,
  input wire word_t   pc,
  input wire word_t   sp,
  input wire opcode_t opcode,
  input wire regIdx_t dstIdx
);

  // Bus requests are exclusive one-cycle pulses
  requestExclusive: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq)) else $error("read and write request in the same cycle");
  readPulse: assert property (@(posedge clk) disable iff (reset)
    readReq |=> !readReq) else $error("read request longer than one cycle");
  writePulse: assert property (@(posedge clk) disable iff (reset)
    writeReq |=> !writeReq) else $error("write request longer than one cycle");
  debugPulse: assert property (@(posedge clk) disable iff (reset)
    debugValid |=> !debugValid) else $error("debug valid longer than one cycle");

  // Word aligned addresses only
  alignedAddress: assert property (@(posedge clk) disable iff (reset)
    (readReq || writeReq) |-> (ramAddress[1:0] == 2'b00)) else $error("unaligned bus address");
  alignedPc: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00) else $error("unaligned program counter");

  // Stack pointer register after the instruction commits
  stackGrow: assert property (@(posedge clk) disable iff (reset)
    (executeStrobe && (opcode == PushR || opcode == CallR))
    |=> (sp == $past(sp) + StackStep))
    else $error("push or call stack step wrong");
  // Pop into r0 lets the loaded value win
  stackShrink: assert property (@(posedge clk) disable iff (reset)
    (executeStrobe && (opcode == Ret || (opcode == PopR && dstIdx != SpReg)))
    |=> (sp == $past(sp) - StackStep))
    else $error("pop or return stack step wrong");

endmodule

bind cpuTop cpuChk i_chk (.*);

`default_nettype wire

/* tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb
  import cpuPkg::*;
();

  logic  clk = 1'b0;
  logic  reset;
  word_t ramIn;
  wire word_t ramAddress;
  wire word_t ramOut;
  wire word_t debugOut;
  wire word_t pc;
  wire        readReq;
  wire        writeReq;
  wire        debugValid;

  word_t  mem [512];        // Program below 0x400, random data above
  integer seed;
  word_t  cursor;           // Program build address
  logic   live;             // Emitted code is executed
  int     curTest;
  word_t  dbgQ[$];          // Expected debug values
  int     dbgTag[$];
  word_t  wrAddrQ[$];       // Expected stores
  word_t  wrDataQ[$];
  int     wrTag[$];
  word_t  traceQ[$];        // Expected fetch addresses in order
  int     traceTag[$];
  int     errs [6];
  string  testName [6];
  int     phase;
  int     cycle;
  int     lastFetch;
  word_t  lastAddr;
  logic   fetchSeen;
  logic   done;
  logic   readPending;      // Read accepted, data not yet on ramIn
  word_t  readAddr;

  cpuTop i_dut (
    .clk        (clk),
    .reset      (reset),
    .ramIn      (ramIn),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .debugOut   (debugOut),
    .debugValid (debugValid),
    .pc         (pc)
  );

  always #4 clk = ~clk;   // 8 ns period

  task automatic checkValue(input int t, input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("ERROR %0t %s got %08h expected %08h", $time, name, got, exp);
      errs[t]++;
    end
  endtask

  task automatic reportTest(input int t);
    $display("Test %0d %s: %s, %0d errors", t, testName[t], (errs[t] == 0) ? "PASS" : "FAIL",
             errs[t]);
  endtask

  // Cycle count from opcode class
  function automatic int instrCycles(input opcode_t op);
    int n;
    n = 5;
    case (op)
      MovRC, AddRRC, SubRRC, MulAddRRC, CmpRC, JmpC, JeC, JneC, JzRC: n = 7;
      MovRdC, MovRdRo, MovRdRoR, MovdCR, MovdRoR, MovdRoRR:             n = 10;
      PushR, PopR, CallR, Ret:                                          n = 8;
      default:                                                          n = 5;
    endcase
    return n;
  endfunction

  task automatic putWord(input word_t w);
    mem[cursor[10:2]] = w;
    cursor = cursor + 32'd4;
  endtask

  task automatic emit(input opcode_t op, input regIdx_t d, input regIdx_t a, input regIdx_t b);
    if (live) begin
      traceQ.push_back(cursor);
      traceTag.push_back(curTest);
    end
    putWord({4'h0, b, 4'h0, a, 4'h0, d, op});
  endtask

  task automatic emitLong(input opcode_t op, input regIdx_t d, input regIdx_t a,
                          input regIdx_t b, input word_t k);
    emit(op, d, a, b);
    putWord(k);   // Constant word
  endtask

  // Forward jump, target patched later
  task automatic emitSlot(input opcode_t op, output word_t slot);
    slot = cursor + 32'd4;
    emitLong(op, 4'd0, 4'd0, 4'd0, '0);
  endtask

  task automatic patch(input word_t slot);
    mem[slot[10:2]] = cursor;
  endtask

  task automatic expectDebug(input word_t v);
    dbgQ.push_back(v);
    dbgTag.push_back(curTest);
  endtask

  task automatic expectWrite(input word_t a, input word_t d);
    wrAddrQ.push_back(a);
    wrDataQ.push_back(d);
    wrTag.push_back(curTest);
  endtask

  task automatic buildProgram();
    word_t res;
    word_t slot1;
    word_t slot2;
    word_t callPc;
    word_t saved;
    cursor  = '0;
    live    = 1'b1;
    curTest = 1;
    emitLong(MovRC, 4'd0, 4'd0, 4'd0, 32'h0000_0600);   // sp
    emitLong(MovRC, 4'd3, 4'd0, 4'd0, 32'h0000_600d);   // Good marker
    emitLong(MovRC, 4'd15, 4'd0, 4'd0, 32'h0000_0bad);  // Marker of dead paths
    // Arithmetic chain
    emitLong(MovRC, 4'd2, 4'd0, 4'd0, 32'h0000_1234);
    emitLong(MovRC, 4'd4, 4'd0, 4'd0, 32'h0001_0101);
    emit(AddRRR, 4'd5, 4'd2, 4'd4);
    emitLong(SubRRC, 4'd5, 4'd5, 4'd0, 32'h0000_0035);
    emitLong(MovRC, 4'd6, 4'd0, 4'd0, 32'd3);
    emit(ShlRRR, 4'd7, 4'd5, 4'd6);
    emit(NegRR, 4'd8, 4'd7, 4'd0);
    emitLong(MulAddRRC, 4'd8, 4'd2, 4'd0, 32'd7);
    emit(DoutR, 4'd8, 4'd0, 4'd0);
    res = -((32'h0000_1234 + 32'h0001_0101 - 32'h0000_0035) << 3) + 32'h0000_1234 * 32'd7;
    expectDebug(res);
    // Stores and loads in each mode
    curTest = 2;
    emitLong(MovRC, 4'd9, 4'd0, 4'd0, 32'h0000_0500);   // Base
    emitLong(MovRC, 4'd10, 4'd0, 4'd0, 32'd2);          // Index
    emitLong(MovRC, 4'd11, 4'd0, 4'd0, 32'hcafe_0001);
    emitLong(MovRC, 4'd13, 4'd0, 4'd0, 32'h1357_9bdf);
    emitLong(MovRC, 4'd14, 4'd0, 4'd0, 32'h8000_00a5);
    emitLong(MovdCR, 4'd0, 4'd11, 4'd0, 32'h0000_0440);
    expectWrite(32'h0000_0440, 32'hcafe_0001);
    emitLong(MovRdC, 4'd12, 4'd0, 4'd0, 32'h0000_0440);
    emit(DoutR, 4'd12, 4'd0, 4'd0);
    expectDebug(32'hcafe_0001);
    emitLong(MovdRoR, 4'd9, 4'd13, 4'd0, 32'h0000_0010);
    expectWrite(32'h0000_0510, 32'h1357_9bdf);
    emitLong(MovRdRo, 4'd12, 4'd9, 4'd0, 32'h0000_0010);
    emit(DoutR, 4'd12, 4'd0, 4'd0);
    expectDebug(32'h1357_9bdf);
    emitLong(MovdRoRR, 4'd9, 4'd10, 4'd14, 32'h0000_0020);  // 0x500 + 0x20 * 2
    expectWrite(32'h0000_0540, 32'h8000_00a5);
    emitLong(MovRdRoR, 4'd12, 4'd9, 4'd10, 32'h0000_0020);
    emit(DoutR, 4'd12, 4'd0, 4'd0);
    expectDebug(32'h8000_00a5);
    emitLong(MovRdC, 4'd12, 4'd0, 4'd0, 32'h0000_0700);  // Random fill word
    emit(DoutR, 4'd12, 4'd0, 4'd0);
    expectDebug(mem[448]);
    // Compares and branches
    curTest = 3;
    emitLong(MovRC, 4'd2, 4'd0, 4'd0, 32'h0000_0055);
    emitLong(CmpRC, 4'd2, 4'd0, 4'd0, 32'h0000_0055);   // Equal
    emitSlot(JeC, slot1);
    live = 1'b0;
    emit(DoutR, 4'd15, 4'd0, 4'd0);
    live = 1'b1;
    patch(slot1);
    emit(DoutR, 4'd3, 4'd0, 4'd0);
    expectDebug(32'h0000_600d);
    emitSlot(JneC, slot1);   // Not taken
    emit(DoutR, 4'd3, 4'd0, 4'd0);
    expectDebug(32'h0000_600d);
    emitSlot(JmpC, slot2);
    live = 1'b0;
    patch(slot1);
    emit(DoutR, 4'd15, 4'd0, 4'd0);
    live = 1'b1;
    patch(slot2);
    emitLong(CmpRC, 4'd2, 4'd0, 4'd0, 32'h0000_0056);   // Unequal
    emitSlot(JeC, slot1);
    emit(DoutR, 4'd3, 4'd0, 4'd0);
    expectDebug(32'h0000_600d);
    emitSlot(JmpC, slot2);
    live = 1'b0;
    patch(slot1);
    emit(DoutR, 4'd15, 4'd0, 4'd0);
    live = 1'b1;
    patch(slot2);
    emitSlot(JneC, slot1);   // Taken
    live = 1'b0;
    emit(DoutR, 4'd15, 4'd0, 4'd0);
    live = 1'b1;
    patch(slot1);
    emit(DoutR, 4'd3, 4'd0, 4'd0);
    expectDebug(32'h0000_600d);
    // Stack, call and return
    curTest = 4;
    emitLong(MovRC, 4'd4, 4'd0, 4'd0, 32'h1234_5678);
    emit(PushR, 4'd4, 4'd0, 4'd0);
    expectWrite(32'h0000_0600, 32'h1234_5678);
    emitLong(MovRC, 4'd5, 4'd0, 4'd0, 32'h0000_0300);
    callPc = cursor;
    emit(CallR, 4'd5, 4'd0, 4'd0);
    expectWrite(32'h0000_0604, callPc);   // Return slot holds the call address
    saved  = cursor;
    cursor = 32'h0000_0300;   // Subroutine
    emit(DoutR, 4'd3, 4'd0, 4'd0);
    expectDebug(32'h0000_600d);
    emit(Ret, 4'd0, 4'd0, 4'd0);
    cursor = saved;   // Back at callPc + 4
    emit(PopR, 4'd6, 4'd0, 4'd0);
    emit(DoutR, 4'd6, 4'd0, 4'd0);
    expectDebug(32'h1234_5678);
    emit(Stall, 4'd0, 4'd0, 4'd0);
  endtask

  // Memory model and monitors, all on the falling edge
  always @(negedge clk) begin : monitor
    int    t;
    word_t expAddr;
    if (!reset) begin
      cycle++;
      if (writeReq) begin
        mem[ramAddress[10:2]] = ramOut;
        if (wrAddrQ.size() == 0) begin
          $display("Unexpected store to %08h at %0t", ramAddress, $time);
          errs[5]++;
        end else begin
          t = wrTag.pop_front();
          checkValue(t, "ramAddress", ramAddress, wrAddrQ.pop_front());
          checkValue(t, "ramOut", ramOut, wrDataQ.pop_front());
        end
      end
      // Read data appears after the request edge and stays until the next request
      if (readPending) begin
        ramIn       = mem[readAddr[10:2]];
        readPending = 1'b0;
      end
      if (readReq) begin
        readPending = 1'b1;
        readAddr    = ramAddress;
      end
      if (debugValid) begin
        if (dbgQ.size() == 0) begin
          $display("Unexpected debug output %08h at %0t", debugOut, $time);
          errs[5]++;
        end else begin
          t = dbgTag.pop_front();
          checkValue(t, "debugOut", debugOut, dbgQ.pop_front());
        end
      end
      if (readReq && i_dut.i_sequencer.state == Fetch) begin
        if (fetchSeen) begin
          checkValue(5, "fetch spacing", word_t'(cycle - lastFetch),
                     word_t'(instrCycles(opcode_t'(mem[lastAddr[10:2]][7:0]))));
        end
        if (traceQ.size() > 0) begin
          t       = traceTag.pop_front();
          expAddr = traceQ.pop_front();
          if (t != phase) begin
            reportTest(phase);   // Previous group done
            phase = t;
          end
          checkValue(t, "fetch ramAddress", ramAddress, expAddr);
          checkValue(t, "pc", pc, expAddr);
          if (traceQ.size() == 0) begin
            done = 1'b1;   // Reached the stall
          end
        end
        fetchSeen = 1'b1;
        lastFetch = cycle;
        lastAddr  = ramAddress;
      end
    end
  end

  initial begin : stimulus
    int waitCycles;
    int total;
    testName[0] = "reset";
    testName[1] = "arithmetic";
    testName[2] = "loads and stores";
    testName[3] = "compares and branches";
    testName[4] = "stack and calls";
    testName[5] = "bus protocol";
    for (int i = 0; i < 6; i++) begin
      errs[i] = 0;
    end
    seed        = 32'ha020_00eb;
    reset       = 1'b1;
    ramIn       = '0;
    phase       = 1;
    cycle       = 0;
    lastFetch   = 0;
    lastAddr    = '0;
    fetchSeen   = 1'b0;
    done        = 1'b0;
    readPending = 1'b0;
    readAddr    = '0;
    for (int i = 0; i < 512; i++) begin
      mem[i] = (i >= 256) ? word_t'($random(seed)) : '0;
    end
    buildProgram();
    repeat (2) begin
      @(negedge clk);
      checkValue(0, "readReq", word_t'(readReq), '0);
      checkValue(0, "writeReq", word_t'(writeReq), '0);
      checkValue(0, "debugValid", word_t'(debugValid), '0);
    end
    reset = 1'b0;
    #1;
    checkValue(0, "readReq", word_t'(readReq), '0);   // First cycle out of reset
    checkValue(0, "pc", pc, '0);
    waitCycles = 0;
    while (!readReq && waitCycles < 10) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!readReq) begin
      $display("No read request after reset");
      errs[0]++;
    end
    checkValue(0, "ramAddress", ramAddress, '0);
    checkValue(0, "writeReq", word_t'(writeReq), '0);
    reportTest(0);
    waitCycles = 0;
    while (!done && waitCycles < 3000) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!done) begin
      $display("Timeout before the program reached its stall");
      $display("Some tests failed");
    end else begin
      repeat (12) @(negedge clk);   // A few stall fetches
      if (dbgQ.size() != 0 || wrAddrQ.size() != 0) begin
        $display("Expected debug outputs or stores never appeared");
        errs[5]++;
      end
      reportTest(phase);
      reportTest(5);
      total = 0;
      for (int i = 0; i < 6; i++) begin
        total += errs[i];
      end
      $display("Tests 6, errors %0d", total);
      if (total == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
cpuPkg.sv
cpuSequencer.sv
regFile.sv
memAddrGen.sv
execUnit.sv
cpuTop.sv
cpu_chk.sv
tb.sv

/* run.sh */
#!/bin/sh
set -e
verilator --binary --timing --assert -f tb.f --top-module tb -o simv
out=$(./obj_dir/simv)
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
  exit 0
else
  exit 1
fi
